// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 8;
	localparam int PADDR_W = 9;
	localparam int MEM_DEPTH = 1 << ADDR_W;
	localparam int NUM_REGS = 4;

	// APB addresses above the memory window.
	localparam logic [PADDR_W-1:0] CTRL_ADDR = 9'h100;
	localparam logic [PADDR_W-1:0] ACC_ADDR = 9'h104;

	// Opcode sits in the low nibble of the first instruction byte.
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_LDI = 4'd1,
		OP_LDM = 4'd2,
		OP_STM = 4'd3,
		OP_ADD = 4'd4,
		OP_SUB = 4'd5,
		OP_AND = 4'd6,
		OP_XOR = 4'd7,
		OP_JMP = 4'd8,
		OP_JZ = 4'd9,
		OP_HALT = 4'd10
	} opcodeT;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_OPERAND,
		ST_LOAD,
		ST_EXEC,
		ST_STORE,
		ST_HALT
	} stateT;

	typedef enum logic [2:0] {ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} aluOpT;

	typedef enum logic [1:0] {BUS_MEM, BUS_ALU, BUS_IR, BUS_ZERO} busSelT;

	// Bit positions inside a one-hot register select.
	typedef enum logic [1:0] {REG_PC, REG_IR, REG_AC, REG_WV} regBitT;

	typedef logic [NUM_REGS-1:0] regSelT;

endpackage

`default_nettype wire

// File: coreCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface coreCtrlIf;
	import cpuPkg::*;

	regSelT wrEn;
	regSelT incEn;
	regSelT rstEn;
	busSelT busSel;
	aluOpT aluOp;
	// High selects WV as the core memory address, low selects PC.
	logic memAddrSel;
	logic memWrite;

	modport control (output wrEn, incEn, rstEn, busSel, aluOp, memAddrSel, memWrite);
	modport regs (input wrEn, incEn, rstEn, busSel);
	modport alu (input aluOp);
	modport mem (input memAddrSel, memWrite);

endinterface

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic clk,
	input logic reset,
	input logic start,
	input logic zero,
	input cpuPkg::opcodeT ir,
	coreCtrlIf.control ctrl,
	output logic running,
	output logic halted
);
	import cpuPkg::*;

	stateT state;
	stateT nextState;
	logic aluPending;
	logic relaunch;

	function automatic aluOpT aluOpOf(opcodeT op);
		case (op)
			OP_ADD: return ALU_ADD;
			OP_SUB: return ALU_SUB;
			OP_AND: return ALU_AND;
			OP_XOR: return ALU_XOR;
			default: return ALU_PASS;
		endcase
	endfunction

	assign running = (state != ST_IDLE) && (state != ST_HALT);
	assign halted = (state == ST_HALT);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			aluPending <= 1'b0;
			relaunch <= 1'b0;
		end else begin
			state <= nextState;
			// The ALU result is written back to AC during the next fetch.
			if (state == ST_EXEC)
				aluPending <= (aluOpOf(ir) != ALU_PASS);
			else if (state == ST_FETCH)
				aluPending <= 1'b0;
			relaunch <= (state == ST_HALT) && start;
		end
	end

	always_comb begin
		nextState = state;
		ctrl.wrEn = '0;
		ctrl.incEn = '0;
		ctrl.rstEn = '0;
		ctrl.busSel = BUS_ZERO;
		ctrl.aluOp = ALU_PASS;
		ctrl.memAddrSel = 1'b0;
		ctrl.memWrite = 1'b0;
		case (state)
			ST_IDLE: begin
				if (start || relaunch) begin
					ctrl.rstEn[REG_PC] = 1'b1;
					nextState = ST_FETCH;
				end
			end
			ST_FETCH: begin
				ctrl.incEn[REG_PC] = 1'b1;
				if (aluPending) begin
					ctrl.busSel = BUS_ALU;
					ctrl.aluOp = aluOpOf(ir);
					ctrl.wrEn[REG_AC] = 1'b1;
				end
				nextState = ST_DECODE;
			end
			ST_DECODE: begin
				// Opcode byte arrives now while the operand read is issued.
				ctrl.busSel = BUS_MEM;
				ctrl.wrEn[REG_IR] = 1'b1;
				ctrl.incEn[REG_PC] = 1'b1;
				nextState = ST_OPERAND;
			end
			ST_OPERAND: begin
				ctrl.busSel = BUS_MEM;
				nextState = ST_FETCH;
				case (ir)
					OP_LDI: ctrl.wrEn[REG_AC] = 1'b1;
					OP_JMP: ctrl.wrEn[REG_PC] = 1'b1;
					OP_JZ: ctrl.wrEn[REG_PC] = zero;
					OP_HALT: nextState = ST_HALT;
					OP_LDM, OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
						ctrl.wrEn[REG_WV] = 1'b1;
						nextState = ST_LOAD;
					end
					OP_STM: begin
						ctrl.wrEn[REG_WV] = 1'b1;
						nextState = ST_STORE;
					end
					default: nextState = ST_FETCH;
				endcase
			end
			ST_LOAD: begin
				ctrl.memAddrSel = 1'b1;
				nextState = ST_EXEC;
			end
			ST_EXEC: begin
				ctrl.memAddrSel = 1'b1;
				ctrl.busSel = BUS_MEM;
				if (ir == OP_LDM)
					ctrl.wrEn[REG_AC] = 1'b1;
				else
					ctrl.wrEn[REG_WV] = 1'b1;
				nextState = ST_FETCH;
			end
			ST_STORE: begin
				ctrl.memAddrSel = 1'b1;
				ctrl.memWrite = 1'b1;
				nextState = ST_FETCH;
			end
			ST_HALT: begin
				if (start)
					nextState = ST_IDLE;
			end
			default: nextState = ST_IDLE;
		endcase
	end

endmodule

`default_nettype wire

// File: regBank.sv
`timescale 1ns/1ps
`default_nettype none

module regBank (
	input logic clk,
	input logic reset,
	coreCtrlIf.regs ctrl,
	input logic [cpuPkg::DATA_W-1:0] memData,
	input logic [cpuPkg::DATA_W-1:0] aluResult,
	output logic [cpuPkg::DATA_W-1:0] pc,
	output logic [cpuPkg::DATA_W-1:0] ir,
	output logic [cpuPkg::DATA_W-1:0] wv,
	output logic [cpuPkg::DATA_W-1:0] acc
);
	import cpuPkg::*;

	logic [DATA_W-1:0] bus;
	logic [DATA_W-1:0] regs [NUM_REGS];

	// Memory and ALU results meet here on the internal bus.
	always_comb begin
		case (ctrl.busSel)
			BUS_MEM: bus = memData;
			BUS_ALU: bus = aluResult;
			BUS_IR: bus = regs[REG_IR];
			default: bus = '0;
		endcase
	end

	// Reset wins over a write, and a write wins over an increment.
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_REGS; i++) begin
			if (reset || ctrl.rstEn[i])
				regs[i] <= '0;
			else if (ctrl.wrEn[i])
				regs[i] <= bus;
			else if (ctrl.incEn[i])
				regs[i] <= regs[i] + 1'b1;
		end
	end

	assign pc = regs[REG_PC];
	assign ir = regs[REG_IR];
	assign wv = regs[REG_WV];
	assign acc = regs[REG_AC];

endmodule

`default_nettype wire

// File: aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	coreCtrlIf.alu ctrl,
	input logic [cpuPkg::DATA_W-1:0] acc,
	input logic [cpuPkg::DATA_W-1:0] wv,
	output logic [cpuPkg::DATA_W-1:0] result,
	output logic zero
);
	import cpuPkg::*;

	// Add and subtract wrap modulo 256.
	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD: result = acc + wv;
			ALU_SUB: result = acc - wv;
			ALU_AND: result = acc & wv;
			ALU_XOR: result = acc ^ wv;
			default: result = wv;
		endcase
	end

	// The flag follows the accumulator so a conditional jump tests AC.
	assign zero = (acc == '0);

endmodule

`default_nettype wire

// File: hostMemory.sv
`timescale 1ns/1ps
`default_nettype none

module hostMemory (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cpuPkg::PADDR_W-1:0] paddr,
	input logic [cpuPkg::DATA_W-1:0] pwdata,
	output logic [cpuPkg::DATA_W-1:0] prdata,
	output logic pslverr,
	coreCtrlIf.mem ctrl,
	input logic [cpuPkg::ADDR_W-1:0] pc,
	input logic [cpuPkg::DATA_W-1:0] wv,
	input logic [cpuPkg::DATA_W-1:0] acc,
	input logic running,
	input logic halted,
	output logic [cpuPkg::DATA_W-1:0] rdData,
	output logic start
);
	import cpuPkg::*;

	logic [DATA_W-1:0] mem [MEM_DEPTH];
	logic [ADDR_W-1:0] coreAddr;
	logic [ADDR_W-1:0] readAddr;
	logic [ADDR_W-1:0] writeAddr;
	logic [DATA_W-1:0] writeData;
	logic writeEn;
	logic access;
	logic isMem;
	logic isCtrl;
	logic isAcc;
	logic hostWrite;

	assign access = psel && penable;
	assign isMem = (paddr[PADDR_W-1:ADDR_W] == '0);
	assign isCtrl = (paddr == CTRL_ADDR);
	assign isAcc = (paddr == ACC_ADDR);

	// The memory belongs to the core while it runs.
	assign pslverr = access && ((isMem && running) || !(isMem || isCtrl || isAcc));
	assign hostWrite = access && pwrite && isMem && !running;

	assign coreAddr = ctrl.memAddrSel ? wv : pc;
	assign readAddr = running ? coreAddr : paddr[ADDR_W-1:0];
	assign writeEn = ctrl.memWrite || hostWrite;
	assign writeAddr = ctrl.memWrite ? coreAddr : paddr[ADDR_W-1:0];
	assign writeData = ctrl.memWrite ? acc : pwdata;

	// A host read address is sampled in the setup phase and the data is ready for access.
	always_ff @(posedge clk) begin
		if (writeEn)
			mem[writeAddr] <= writeData;
		rdData <= mem[readAddr];
	end

	always_ff @(posedge clk) begin
		if (reset)
			start <= 1'b0;
		else
			start <= access && pwrite && isCtrl && pwdata[0] && !running;
	end

	always_comb begin
		if (isCtrl)
			prdata = {{(DATA_W-2){1'b0}}, halted, running};
		else if (isAcc)
			prdata = acc;
		else if (isMem)
			prdata = rdData;
		else
			prdata = '0;
	end

endmodule

`default_nettype wire

// File: cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cpuPkg::PADDR_W-1:0] paddr,
	input logic [cpuPkg::DATA_W-1:0] pwdata,
	output logic [cpuPkg::DATA_W-1:0] prdata,
	output logic pslverr,
	output logic pready
);
	import cpuPkg::*;

	coreCtrlIf ctrlBus ();

	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] ir;
	logic [DATA_W-1:0] wv;
	logic [DATA_W-1:0] acc;
	logic [DATA_W-1:0] memData;
	logic [DATA_W-1:0] aluResult;
	logic zero;
	logic start;
	logic running;
	logic halted;

	// Every transfer completes without wait states.
	assign pready = 1'b1;

	controlUnit u_controlUnit (
		.clk(clk),
		.reset(reset),
		.start(start),
		.zero(zero),
		.ir(opcodeT'(ir[3:0])),
		.ctrl(ctrlBus.control),
		.running(running),
		.halted(halted)
	);

	regBank u_regBank (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrlBus.regs),
		.memData(memData),
		.aluResult(aluResult),
		.pc(pc),
		.ir(ir),
		.wv(wv),
		.acc(acc)
	);

	aluUnit u_aluUnit (
		.ctrl(ctrlBus.alu),
		.acc(acc),
		.wv(wv),
		.result(aluResult),
		.zero(zero)
	);

	hostMemory u_hostMemory (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pslverr(pslverr),
		.ctrl(ctrlBus.mem),
		.pc(pc),
		.wv(wv),
		.acc(acc),
		.running(running),
		.halted(halted),
		.rdData(memData),
		.start(start)
	);

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk
);
	// Half of the 100 ns clock period.
	localparam int HALF_PERIOD = 50;

	initial clk = 1'b0;

	always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: cpuTop_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop_props (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic running,
	input logic halted,
	input logic memWrite
);
	int failCount = 0;

	// An error response only exists while a transfer is in its access phase.
	errInAccess: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> (psel && penable))
	else begin
		failCount++;
		$error("PSLVERR is high outside an APB access phase");
	end

	runXorHalt: assert property (@(posedge clk) disable iff (reset)
		!(running && halted))
	else begin
		failCount++;
		$error("running and halted are high together");
	end

	// The core owns the memory port only while it runs.
	storeWhileRunning: assert property (@(posedge clk) disable iff (reset)
		memWrite |-> running)
	else begin
		failCount++;
		$error("core memory write while the core is not running");
	end

endmodule

`default_nettype wire

// File: cpuTop_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop_tb;
	import cpuPkg::*;

	// About twice the summed length of the tests, in clock cycles.
	localparam int MAX_CYCLES = 4000;
	localparam int SAMPLE_DELAY = 25;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [PADDR_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata;
	logic [DATA_W-1:0] prdata;
	logic pslverr;
	logic pready;
	logic [15:0] lfsrState = 16'd49923;
	logic [7:0] progBytes [$];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	tbClock u_tbClock (
		.clk(clk)
	);

	cpuTop u_cpuTop (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pslverr(pslverr),
		.pready(pready)
	);

	bind cpuTop cpuTop_props u_cpuTopProps (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pslverr(pslverr),
		.running(running),
		.halted(halted),
		.memWrite(ctrlBus.memWrite)
	);

	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		logic [15:0] shifted;
		shifted = state >> 1;
		if (state[0])
			shifted = shifted ^ 16'hB400;
		return shifted;
	endfunction

	task automatic drawBits(input int count, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[6:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	task automatic checkValue(input logic [7:0] actual, input logic [7:0] expected,
			input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic apbWrite(input logic [8:0] addr, input logic [7:0] data, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#SAMPLE_DELAY;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input logic [8:0] addr, output logic [7:0] data, output logic err);
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#SAMPLE_DELAY;
		data = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic hostWrite(input logic [8:0] addr, input logic [7:0] data);
		logic err;
		apbWrite(addr, data, err);
		checkValue(8'(err), 8'h00, $sformatf("PSLVERR on write to %h", addr));
	endtask

	task automatic expectRead(input logic [8:0] addr, input logic [7:0] expected,
			input string what);
		logic [7:0] data;
		logic err;
		apbRead(addr, data, err);
		checkValue(8'(err), 8'h00, $sformatf("PSLVERR on read of %h", addr));
		checkValue(data, expected, what);
	endtask

	// Each instruction is an opcode byte followed by its operand byte.
	task automatic emit(input opcodeT op, input logic [7:0] operand);
		progBytes.push_back({4'h0, op});
		progBytes.push_back(operand);
	endtask

	task automatic loadProgram();
		foreach (progBytes[i])
			hostWrite(9'(i), progBytes[i]);
		progBytes.delete();
	endtask

	task automatic waitHalted();
		logic [7:0] status;
		logic err;
		do begin
			apbRead(CTRL_ADDR, status, err);
		end while (status[1] !== 1'b1);
		checkValue(status, 8'h02, "status after halt");
	endtask

	task automatic runProgram();
		loadProgram();
		hostWrite(CTRL_ADDR, 8'h01);
		waitHalted();
	endtask

	task automatic resetAndMemory();
		logic [7:0] addrs [32];
		logic [7:0] model [256];
		logic [7:0] data;
		expectRead(CTRL_ADDR, 8'h00, "status after reset");
		expectRead(ACC_ADDR, 8'h00, "AC after reset");
		checkValue(8'(pready), 8'h01, "PREADY tied high");
		for (int i = 0; i < 32; i++) begin
			drawBits(8, addrs[i]);
			drawBits(8, data);
			model[addrs[i]] = data;
			hostWrite({1'b0, addrs[i]}, data);
		end
		for (int i = 0; i < 32; i++)
			expectRead({1'b0, addrs[i]}, model[addrs[i]], $sformatf("memory byte %h", addrs[i]));
	endtask

	task automatic arithmeticProgram();
		logic [7:0] a;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] sum;
		drawBits(8, a);
		drawBits(8, x);
		drawBits(8, y);
		hostWrite(9'h0A0, x);
		hostWrite(9'h0A1, y);
		emit(OP_LDI, a);
		emit(OP_ADD, 8'hA0);
		emit(OP_SUB, 8'hA1);
		emit(OP_HALT, 8'h00);
		runProgram();
		sum = a + x;
		sum = sum - y;
		expectRead(ACC_ADDR, sum, "AC after add and subtract");
	endtask

	task automatic logicStoreProgram();
		logic [7:0] a;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] first;
		logic [7:0] second;
		drawBits(8, a);
		drawBits(8, x);
		drawBits(8, y);
		hostWrite(9'h0B0, x);
		hostWrite(9'h0B1, y);
		emit(OP_LDI, a);
		emit(OP_AND, 8'hB0);
		emit(OP_STM, 8'hB2);
		emit(OP_XOR, 8'hB1);
		emit(OP_STM, 8'hB3);
		emit(OP_HALT, 8'h00);
		runProgram();
		first = a & x;
		second = first ^ y;
		expectRead(9'h0B2, first, "stored AND result");
		expectRead(9'h0B3, second, "stored XOR result");
		expectRead(ACC_ADDR, second, "AC after logic program");
	endtask

	// Counts the remaining value at 0x91 down to zero and the cell at 0x90 up.
	task automatic countdownLoop();
		logic [7:0] count;
		drawBits(4, count);
		count = count + 8'd1;
		hostWrite(9'h091, count);
		hostWrite(9'h092, 8'h01);
		emit(OP_LDI, 8'h00);
		emit(OP_STM, 8'h90);
		emit(OP_LDM, 8'h91);
		emit(OP_JZ, 8'h14);
		emit(OP_SUB, 8'h92);
		emit(OP_STM, 8'h91);
		emit(OP_LDM, 8'h90);
		emit(OP_ADD, 8'h92);
		emit(OP_STM, 8'h90);
		emit(OP_JMP, 8'h04);
		emit(OP_HALT, 8'h00);
		runProgram();
		expectRead(ACC_ADDR, 8'h00, "AC after countdown");
		expectRead(9'h090, count, "counter cell after countdown");
		expectRead(9'h091, 8'h00, "remaining count after countdown");
	endtask

	task automatic busyHostAccess();
		logic [7:0] status;
		logic [7:0] data;
		logic err;
		hostWrite(9'h0C0, 8'h5A);
		hostWrite(9'h0C1, 8'd30);
		hostWrite(9'h0C2, 8'h01);
		hostWrite(9'h0C3, 8'h00);
		// The cell at 0xC3 counts how often the program has been started.
		emit(OP_LDM, 8'hC3);
		emit(OP_ADD, 8'hC2);
		emit(OP_STM, 8'hC3);
		emit(OP_LDM, 8'hC1);
		emit(OP_SUB, 8'hC2);
		emit(OP_JZ, 8'h0E);
		emit(OP_JMP, 8'h08);
		emit(OP_HALT, 8'h00);
		loadProgram();
		hostWrite(CTRL_ADDR, 8'h01);
		do begin
			apbRead(CTRL_ADDR, status, err);
		end while (status[0] !== 1'b1);
		apbWrite(9'h0C0, 8'hA5, err);
		checkValue(8'(err), 8'h01, "PSLVERR on memory write while running");
		apbRead(9'h0C0, data, err);
		checkValue(8'(err), 8'h01, "PSLVERR on memory read while running");
		apbRead(9'h108, data, err);
		checkValue(8'(err), 8'h01, "PSLVERR on unmapped read");
		apbWrite(9'h1F0, 8'h00, err);
		checkValue(8'(err), 8'h01, "PSLVERR on unmapped write");
		hostWrite(CTRL_ADDR, 8'h01);
		waitHalted();
		repeat (4) @(negedge clk);
		expectRead(CTRL_ADDR, 8'h02, "status stays halted after an ignored start");
		expectRead(ACC_ADDR, 8'h00, "AC after busy countdown");
		expectRead(9'h0C0, 8'h5A, "byte written while running");
		expectRead(9'h0C3, 8'h01, "start count after an ignored start");
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MAX_CYCLES) begin
			$display("ERROR: timeout, the run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		resetAndMemory();
		arithmeticProgram();
		logicStoreProgram();
		countdownLoop();
		busyHostAccess();
		errorCount = errorCount + u_cpuTop.u_cpuTopProps.failCount;
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
cpuPkg.sv
coreCtrlIf.sv
controlUnit.sv
regBank.sv
aluUnit.sv
hostMemory.sv
cpuTop.sv
tbClock.sv
cpuTop_props.sv
cpuTop_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpuTop_tb \
	-f project.f -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -qx "TEST PASSED" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
